//--- source/isa_pkg.sv
`default_nettype none

package isa_pkg;

	// basic data and index types.
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	// instruction field positions.
	localparam int OPC_MSB   = 31;
	localparam int OPC_LSB   = 26;
	localparam int RS_MSB    = 25;
	localparam int RS_LSB    = 21;
	localparam int RT_MSB    = 20;
	localparam int RT_LSB    = 16;
	localparam int RD_MSB    = 15;
	localparam int RD_LSB    = 11;
	localparam int IMM_MSB   = 15;
	localparam int IMM_LSB   = 0;
	localparam int FUNCT_MSB = 3;
	localparam int FUNCT_LSB = 0;

	// shifts use only the low bits of operand b.
	localparam int SHAMT_W = 5;

	// major opcodes in bits 31..26.
	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_ADDI  = 6'b001000,
		OP_ANDI  = 6'b001100,
		OP_ORI   = 6'b001101,
		OP_XORI  = 6'b001110,
		OP_ST    = 6'b010000,
		OP_LD    = 6'b010001,
		OP_LDB   = 6'b110000,
		OP_STB   = 6'b111000
	} opcode_e;

	// r-type function field in bits 3..0.
	typedef enum logic [3:0] {
		F_ADD = 4'h0,
		F_SUB = 4'h1,
		F_AND = 4'h2,
		F_OR  = 4'h3,
		F_XOR = 4'h4,
		F_SLT = 4'h5,
		F_SLL = 4'h6,
		F_SRL = 4'h7
	} funct_e;

endpackage

`default_nettype wire

//--- source/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	// operations the alu understands.
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL
	} alu_op_e;

	// source of the writeback word.
	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_MEM  = 2'd1,
		WB_NONE = 2'd2
	} wb_sel_e;

	// everything decode tells the rest of the slice.
	typedef struct packed {
		alu_op_e           alu_op;
		logic              alusrc;
		isa_pkg::word_t    imm;
		logic [3:0]        mem_write;
		logic              mem_read;
		logic              mem_byte;
		wb_sel_e           wb_sel;
		isa_pkg::reg_idx_t wb_reg;
		logic              wb_en;
		logic              illegal;
	} dec_ctrl_t;

	typedef struct packed {
		logic           psel;
		logic           penable;
		logic           pwrite;
		logic [3:0]     paddr;
		isa_pkg::word_t pwdata;
	} apb_req_t;

	typedef struct packed {
		isa_pkg::word_t prdata;
		logic           pready;
		logic           pslverr;
	} apb_rsp_t;

	typedef enum logic [2:0] {
		IDLE,
		DECODE,
		EXECUTE,
		MEMORY,
		WRITEBACK,
		DONE
	} seq_state_e;

	// apb register map.
	localparam logic [3:0] REG_INSTR = 4'h0;
	localparam logic [3:0] REG_SEL   = 4'h4;
	localparam logic [3:0] REG_DATA  = 4'h8;
	localparam logic [3:0] REG_CTRL  = 4'hC;

	// bits of REG_CTRL.
	localparam int CTRL_SAVE_BIT    = 0;
	localparam int CTRL_RESTORE_BIT = 1;

endpackage

`default_nettype wire

//--- source/regfile_shadow.sv
`timescale 1ns/1ps
`default_nettype none

module regfile_shadow (
	input  logic              clk,
	input  logic              rst,
	input  isa_pkg::reg_idx_t rd1_sel,
	input  isa_pkg::reg_idx_t rd2_sel,
	input  isa_pkg::reg_idx_t rd3_sel,
	input  logic              wr_en,
	input  isa_pkg::reg_idx_t wr_sel,
	input  isa_pkg::word_t    wr_data,
	input  logic              save,
	input  logic              restore,
	output isa_pkg::word_t    rd1,
	output isa_pkg::word_t    rd2,
	output isa_pkg::word_t    rd3
);

	import isa_pkg::*;

	localparam int NREGS = 2 ** $bits(reg_idx_t);

	word_t regs   [NREGS];
	word_t shadow [NREGS];

	// register 0 is never written, so it stays zero from reset.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i]   <= '0;
				shadow[i] <= '0;
			end
		end else if (save) begin
			shadow <= regs;
		end else if (restore) begin
			regs <= shadow;
		end else if (wr_en && wr_sel != '0) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// asynchronous reads.
	assign rd1 = regs[rd1_sel];
	assign rd2 = regs[rd2_sel];
	assign rd3 = regs[rd3_sel];

	// the sequencer must never ask for both copies at once.
	a_save_xor_restore: assert property (
		@(posedge clk) disable iff (rst) !(save && restore)
	);

endmodule

`default_nettype wire

//--- source/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode (
	input  isa_pkg::word_t     instr,
	output isa_pkg::reg_idx_t  rs,
	output isa_pkg::reg_idx_t  rt,
	output ctrl_pkg::dec_ctrl_t ctrl
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	opcode_e          opc;
	funct_e           fn;
	logic [15:0]      imm16;
	alu_op_e          alu_op;
	logic             alusrc;
	logic             op_bad;
	word_t            imm;
	logic [3:0]       mem_write;
	logic             mem_read;
	logic             mem_byte;
	wb_sel_e          wb_sel;
	reg_idx_t         wb_reg;
	logic             wb_en;

	assign opc   = opcode_e'(instr[OPC_MSB:OPC_LSB]);
	assign fn    = funct_e'(instr[FUNCT_MSB:FUNCT_LSB]);
	assign imm16 = instr[IMM_MSB:IMM_LSB];

	// register file selects.
	assign rs = instr[RS_MSB:RS_LSB];
	assign rt = instr[RT_MSB:RT_LSB];

	// alu control.
	always_comb begin
		alu_op = ALU_ADD;
		alusrc = 1'b1;
		op_bad = 1'b0;
		case (opc)
			OP_RTYPE: begin
				alusrc = 1'b0;
				case (fn)
					F_ADD:   alu_op = ALU_ADD;
					F_SUB:   alu_op = ALU_SUB;
					F_AND:   alu_op = ALU_AND;
					F_OR:    alu_op = ALU_OR;
					F_XOR:   alu_op = ALU_XOR;
					F_SLT:   alu_op = ALU_SLT;
					F_SLL:   alu_op = ALU_SLL;
					F_SRL:   alu_op = ALU_SRL;
					default: op_bad = 1'b1;
				endcase
			end
			OP_ADDI, OP_LD, OP_ST, OP_LDB, OP_STB: alu_op = ALU_ADD;
			OP_ANDI: alu_op = ALU_AND;
			OP_ORI:  alu_op = ALU_OR;
			OP_XORI: alu_op = ALU_XOR;
			default: op_bad = 1'b1;
		endcase
	end

	// logical immediates zero-extend, the rest sign-extend.
	always_comb begin
		case (opc)
			OP_ANDI, OP_ORI, OP_XORI: imm = {16'b0, imm16};
			default:                  imm = {{16{imm16[15]}}, imm16};
		endcase
	end

	// memory control.
	always_comb begin
		mem_write = 4'b0000;
		mem_read  = 1'b0;
		mem_byte  = 1'b0;
		case (opc)
			OP_ST:  mem_write = 4'b1111;
			OP_STB: mem_write = 4'b0001;
			OP_LD:  mem_read  = 1'b1;
			OP_LDB: begin
				mem_read = 1'b1;
				mem_byte = 1'b1;
			end
			default: ;
		endcase
	end

	// writeback control.
	always_comb begin
		wb_sel = WB_NONE;
		wb_reg = '0;
		wb_en  = 1'b0;
		case (opc)
			OP_RTYPE: begin
				wb_sel = WB_ALU;
				wb_reg = instr[RD_MSB:RD_LSB];
				wb_en  = 1'b1;
			end
			OP_ADDI, OP_ANDI, OP_ORI, OP_XORI: begin
				wb_sel = WB_ALU;
				wb_reg = rt;
				wb_en  = 1'b1;
			end
			OP_LD, OP_LDB: begin
				wb_sel = WB_MEM;
				wb_reg = rt;
				wb_en  = 1'b1;
			end
			default: ;
		endcase
	end

	assign ctrl = '{
		alu_op:    alu_op,
		alusrc:    alusrc,
		imm:       imm,
		mem_write: mem_write,
		mem_read:  mem_read,
		mem_byte:  mem_byte,
		wb_sel:    wb_sel,
		wb_reg:    wb_reg,
		wb_en:     wb_en,
		illegal:   op_bad
	};

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  isa_pkg::word_t    a,
	input  isa_pkg::word_t    b,
	input  ctrl_pkg::alu_op_e op,
	output isa_pkg::word_t    y
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	logic [SHAMT_W-1:0] shamt;

	assign shamt = b[SHAMT_W-1:0];

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR:  y = a | b;
			ALU_XOR: y = a ^ b;
			// signed compare giving 0 or 1.
			ALU_SLT: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLL: y = a << shamt;
			ALU_SRL: y = a >> shamt;
			default: y = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
	parameter int MEM_WORDS = 64
) (
	input  logic           clk,
	input  isa_pkg::word_t addr,
	input  isa_pkg::word_t wdata,
	input  logic [3:0]     write,
	input  logic           byte_sel,
	output isa_pkg::word_t rdata
);

	import isa_pkg::*;

	localparam int AW = $clog2(MEM_WORDS);

	word_t         mem [MEM_WORDS];
	logic [AW-1:0] idx;
	word_t         word;

	// byte address to word index.
	assign idx = addr[AW+1:2];

	// one write enable per byte lane.
	always_ff @(posedge clk) begin
		for (int lane = 0; lane < 4; lane++) begin
			if (write[lane]) begin
				mem[idx][lane*8 +: 8] <= wdata[lane*8 +: 8];
			end
		end
	end

	assign word = mem[idx];

	// byte loads take lane 0, zero-extended.
	assign rdata = byte_sel ? {24'b0, word[7:0]} : word;

endmodule

`default_nettype wire

//--- source/exec_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module exec_sequencer #(
	parameter int MEM_WORDS = 64
) (
	input  logic                clk,
	input  logic                rst,
	input  ctrl_pkg::apb_req_t  apb_req,
	output ctrl_pkg::apb_rsp_t  apb_rsp,
	input  ctrl_pkg::dec_ctrl_t ctrl,
	input  isa_pkg::word_t      rd1,
	input  isa_pkg::word_t      rd2,
	input  isa_pkg::word_t      rd3,
	input  isa_pkg::word_t      alu_y,
	input  isa_pkg::word_t      mem_rdata,
	output isa_pkg::word_t      instr,
	output isa_pkg::reg_idx_t   rd_sel,
	output isa_pkg::word_t      alu_a,
	output isa_pkg::word_t      alu_b,
	output logic                wr_en,
	output isa_pkg::reg_idx_t   wr_sel,
	output isa_pkg::word_t      wr_data,
	output logic                save,
	output logic                restore,
	output isa_pkg::word_t      mem_addr,
	output isa_pkg::word_t      mem_wdata,
	output logic [3:0]          mem_write
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	seq_state_e state;
	reg_idx_t   sel_q;
	word_t      opa_q;
	word_t      opb_q;
	word_t      alu_q;
	word_t      mem_q;
	word_t      prdata;
	logic       setup;
	logic       access;
	logic       instr_wr;
	logic       start;
	logic       reg_xfer;
	logic       ctrl_wr;
	logic       mem_op;
	logic       addr_ok;
	logic       bad;

	assign setup    = apb_req.psel && !apb_req.penable;
	assign access   = apb_req.psel && apb_req.penable;
	assign instr_wr = apb_req.pwrite && apb_req.paddr == REG_INSTR;
	assign start    = setup && instr_wr && (state == IDLE || state == DONE);

	// every other register completes in its first access cycle.
	assign reg_xfer = access && !instr_wr && state == IDLE;
	assign ctrl_wr  = reg_xfer && apb_req.pwrite && apb_req.paddr == REG_CTRL;

	// range check on the latched byte address.
	assign mem_op  = ctrl.mem_read || |ctrl.mem_write;
	assign addr_ok = alu_q[31:2] < 30'(MEM_WORDS);
	assign bad     = ctrl.illegal || (mem_op && !addr_ok);

	// a setup can already sit on the bus in DONE.
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE, DONE: state <= start ? DECODE : IDLE;
				DECODE:     state <= EXECUTE;
				EXECUTE:    state <= MEMORY;
				MEMORY:     state <= WRITEBACK;
				WRITEBACK:  state <= DONE;
				default:    state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sel_q <= '0;
		end else if (reg_xfer && apb_req.pwrite && apb_req.paddr == REG_SEL) begin
			sel_q <= apb_req.pwdata[$bits(reg_idx_t)-1:0];
		end
	end

	// instruction and per-step results.
	always_ff @(posedge clk) begin
		if (start) begin
			instr <= apb_req.pwdata;
		end
		if (state == DECODE) begin
			opa_q <= rd1;
			opb_q <= ctrl.alusrc ? ctrl.imm : rd2;
		end
		if (state == EXECUTE) begin
			alu_q <= alu_y;
		end
		if (state == MEMORY) begin
			mem_q <= mem_rdata;
		end
	end

	assign alu_a = opa_q;
	assign alu_b = opb_q;

	// the memory port writes only in MEMORY.
	assign mem_addr  = alu_q;
	assign mem_wdata = rd2;
	assign mem_write = (state == MEMORY && !bad) ? ctrl.mem_write : 4'b0000;

	// register file write port.
	assign wr_en   = state == WRITEBACK && ctrl.wb_en && !bad;
	assign wr_sel  = ctrl.wb_reg;
	assign wr_data = (ctrl.wb_sel == WB_MEM) ? mem_q : alu_q;

	// save wins if both bits are written.
	assign save    = ctrl_wr && apb_req.pwdata[CTRL_SAVE_BIT];
	assign restore = ctrl_wr && apb_req.pwdata[CTRL_RESTORE_BIT]
		&& !apb_req.pwdata[CTRL_SAVE_BIT];

	// read mux.
	assign rd_sel = sel_q;

	always_comb begin
		prdata = '0;
		if (reg_xfer && !apb_req.pwrite) begin
			case (apb_req.paddr)
				REG_INSTR: prdata = instr;
				REG_SEL:   prdata = word_t'(sel_q);
				REG_DATA:  prdata = rd3;
				default:   prdata = '0;
			endcase
		end
	end

	assign apb_rsp = '{
		prdata:  prdata,
		pready:  reg_xfer || state == WRITEBACK,
		pslverr: state == WRITEBACK && bad
	};

	// the master must still be in its access phase when we answer.
	a_pready_in_access: assert property (
		@(posedge clk) disable iff (rst) apb_rsp.pready |-> access
	);

	// an illegal instruction never reaches the register file.
	a_no_wb_illegal: assert property (
		@(posedge clk) disable iff (rst)
		wr_en |-> instr[OPC_MSB:OPC_LSB] inside {OP_RTYPE, OP_ADDI, OP_ANDI, OP_ORI,
			OP_XORI, OP_LD, OP_LDB}
			&& !(instr[OPC_MSB:OPC_LSB] == OP_RTYPE
			&& instr[FUNCT_MSB:FUNCT_LSB] > F_SRL)
	);

endmodule

`default_nettype wire

//--- source/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top #(
	parameter int MEM_WORDS = 64
) (
	input  logic               clk,
	input  logic               rst,
	input  ctrl_pkg::apb_req_t apb_req,
	output ctrl_pkg::apb_rsp_t apb_rsp
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	word_t      instr;
	word_t      rd1;
	word_t      rd2;
	word_t      rd3;
	word_t      alu_a;
	word_t      alu_b;
	word_t      alu_y;
	word_t      wr_data;
	word_t      mem_addr;
	word_t      mem_wdata;
	word_t      mem_rdata;
	reg_idx_t   rs;
	reg_idx_t   rt;
	reg_idx_t   rd_sel;
	reg_idx_t   wr_sel;
	dec_ctrl_t  ctrl;
	logic       wr_en;
	logic       save;
	logic       restore;
	logic [3:0] mem_write;

	exec_sequencer #(
		.MEM_WORDS(MEM_WORDS)
	) u_seq (
		.clk       (clk),
		.rst       (rst),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.ctrl      (ctrl),
		.rd1       (rd1),
		.rd2       (rd2),
		.rd3       (rd3),
		.alu_y     (alu_y),
		.mem_rdata (mem_rdata),
		.instr     (instr),
		.rd_sel    (rd_sel),
		.alu_a     (alu_a),
		.alu_b     (alu_b),
		.wr_en     (wr_en),
		.wr_sel    (wr_sel),
		.wr_data   (wr_data),
		.save      (save),
		.restore   (restore),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_write (mem_write)
	);

	decode u_dec (
		.instr (instr),
		.rs    (rs),
		.rt    (rt),
		.ctrl  (ctrl)
	);

	// rd3 serves APB reads.
	regfile_shadow u_rf (
		.clk     (clk),
		.rst     (rst),
		.rd1_sel (rs),
		.rd2_sel (rt),
		.rd3_sel (rd_sel),
		.wr_en   (wr_en),
		.wr_sel  (wr_sel),
		.wr_data (wr_data),
		.save    (save),
		.restore (restore),
		.rd1     (rd1),
		.rd2     (rd2),
		.rd3     (rd3)
	);

	alu u_alu (
		.a  (alu_a),
		.b  (alu_b),
		.op (ctrl.alu_op),
		.y  (alu_y)
	);

	data_mem #(
		.MEM_WORDS(MEM_WORDS)
	) u_mem (
		.clk      (clk),
		.addr     (mem_addr),
		.wdata    (mem_wdata),
		.write    (mem_write),
		.byte_sel (ctrl.mem_byte),
		.rdata    (mem_rdata)
	);

endmodule

`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

	// reset is released on a falling edge.
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

//--- verif/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

	import isa_pkg::*;
	import ctrl_pkg::*;

	localparam int          CLK_PERIOD_NS = 40;
	localparam int          RESET_CYCLES  = 10;
	localparam int          MEM_WORDS     = 64;
	localparam int          SAMPLE_DELAY  = CLK_PERIOD_NS / 4;
	localparam int          MAX_WAIT      = 16;
	localparam int          INSTR_CYCLES  = 4;
	localparam logic [31:0] SEED          = 32'hed23_2484;

	localparam int N_FILL     = 30;
	localparam int N_ALU      = 40;
	localparam int N_IMM      = 30;
	localparam int N_PREFILL  = 8;
	localparam int N_MEM      = 40;
	localparam int N_SCRAMBLE = 20;

	// upper bound on transfers over all tests.
	localparam int N_XFERS = 4 * N_FILL + 3 * N_ALU + 3 * N_IMM + 4 * N_PREFILL
		+ 3 * N_MEM + N_SCRAMBLE + 2 + 64 + 72;
	localparam int WATCHDOG_NS = (N_XFERS * 10 + RESET_CYCLES + 100) * CLK_PERIOD_NS;

	logic     clk;
	logic     rst;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	word_t model_regs   [32];
	word_t model_shadow [32];
	word_t model_mem    [MEM_WORDS];

	int    n_checks;
	int    n_errors;
	int    test_checks0;
	int    test_errors0;
	int    t6_checks;
	int    t6_errors;
	string cur_test;

	tb_clock #(
		.PERIOD_NS    (CLK_PERIOD_NS),
		.RESET_CYCLES (RESET_CYCLES)
	) u_clk (
		.clk (clk),
		.rst (rst)
	);

	core_top #(
		.MEM_WORDS(MEM_WORDS)
	) uut (
		.clk     (clk),
		.rst     (rst),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp)
	);

	function automatic word_t enc_r(input logic [3:0] fn, input reg_idx_t rd,
		input reg_idx_t rs, input reg_idx_t rt);
		return {OP_RTYPE, rs, rt, rd, 7'b0, fn};
	endfunction

	function automatic word_t enc_i(input opcode_e opc, input reg_idx_t rt,
		input reg_idx_t rs, input logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic reg_idx_t rand_reg(input int lo, input int hi);
		return reg_idx_t'($urandom_range(hi, lo));
	endfunction

	function automatic logic is_legal_opcode(input logic [5:0] opc);
		case (opc)
			OP_RTYPE, OP_ADDI, OP_ANDI, OP_ORI, OP_XORI: return 1'b1;
			OP_ST, OP_LD, OP_LDB, OP_STB:                return 1'b1;
			default:                                     return 1'b0;
		endcase
	endfunction

	// r0 stays zero.
	function automatic void set_model_reg(input reg_idx_t idx, input word_t value);
		if (idx != 5'd0) begin
			model_regs[idx] = value;
		end
	endfunction

	// reference model of one instruction that returns the expected pslverr.
	function automatic logic model_exec(input word_t ins);
		logic [5:0]  opc;
		logic [3:0]  fn;
		reg_idx_t    rs;
		reg_idx_t    rt;
		reg_idx_t    rd;
		word_t       a;
		word_t       b;
		word_t       sext;
		word_t       zext;
		word_t       addr;
		word_t       res;
		int unsigned idx;
		opc  = ins[31:26];
		fn   = ins[3:0];
		rs   = ins[25:21];
		rt   = ins[20:16];
		rd   = ins[15:11];
		a    = model_regs[rs];
		b    = model_regs[rt];
		sext = {{16{ins[15]}}, ins[15:0]};
		zext = {16'h0000, ins[15:0]};
		addr = a + sext;
		if (opc == OP_RTYPE) begin
			case (fn)
				F_ADD:   res = a + b;
				F_SUB:   res = a - b;
				F_AND:   res = a & b;
				F_OR:    res = a | b;
				F_XOR:   res = a ^ b;
				F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				F_SLL:   res = a << b[4:0];
				F_SRL:   res = a >> b[4:0];
				default: return 1'b1;
			endcase
			set_model_reg(rd, res);
			return 1'b0;
		end
		case (opc)
			OP_ADDI: set_model_reg(rt, a + sext);
			OP_ANDI: set_model_reg(rt, a & zext);
			OP_ORI:  set_model_reg(rt, a | zext);
			OP_XORI: set_model_reg(rt, a ^ zext);
			OP_LD, OP_LDB, OP_ST, OP_STB: begin
				if (addr[31:2] >= MEM_WORDS) begin
					return 1'b1;
				end
				idx = addr[31:2];
				case (opc)
					OP_LD:   set_model_reg(rt, model_mem[idx]);
					OP_LDB:  set_model_reg(rt, {24'h0, model_mem[idx][7:0]});
					OP_ST:   model_mem[idx] = b;
					default: model_mem[idx][7:0] = b[7:0];
				endcase
			end
			default: return 1'b1;
		endcase
		return 1'b0;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("[FAIL] %s expected %08h actual %08h", name, exp, act);
		end
	endtask

	task automatic check_slverr(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("[FAIL] %s pslverr expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_ready(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("[FAIL] %s pready expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_latency(input string name, input int exp, input int act);
		n_checks++;
		t6_checks++;
		if (act != exp) begin
			n_errors++;
			t6_errors++;
			$display("[FAIL] %s access cycles expected %0d actual %0d", name, exp, act);
		end
	endtask

	// one apb transfer sampled mid low phase.
	task automatic run_transfer(input logic write, input logic [3:0] addr, input word_t wdata,
		output word_t rdata, output logic slverr, output int cycles);
		@(negedge clk);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(negedge clk);
		apb_req.penable = 1'b1;
		cycles = 1;
		#(SAMPLE_DELAY);
		while (!apb_rsp.pready && cycles < MAX_WAIT) begin
			@(negedge clk);
			cycles++;
			#(SAMPLE_DELAY);
		end
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		if (!apb_rsp.pready) begin
			n_errors++;
			$display("%s: no pready after %0d access cycles at address %0h",
				cur_test, cycles, addr);
		end
		@(negedge clk);
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input word_t wdata,
		output logic slverr, output int cycles);
		word_t rdata;
		run_transfer(1'b1, addr, wdata, rdata, slverr, cycles);
	endtask

	task automatic apb_read(input logic [3:0] addr, output word_t rdata);
		logic slverr;
		int   cycles;
		run_transfer(1'b0, addr, '0, rdata, slverr, cycles);
	endtask

	task automatic exec_instr(input word_t ins);
		logic  exp_err;
		logic  slverr;
		int    cycles;
		string name;
		name    = $sformatf("%s instr %08h", cur_test, ins);
		exp_err = model_exec(ins);
		apb_write(REG_INSTR, ins, slverr, cycles);
		check_slverr(name, exp_err, slverr);
		check_latency(name, INSTR_CYCLES, cycles);
	endtask

	// builds a full word from two 16 bit halves with r31 holding the shift.
	task automatic load_reg(input reg_idx_t idx, input word_t value);
		exec_instr(enc_i(OP_ORI, 5'd31, 5'd0, 16'd16));
		exec_instr(enc_i(OP_ORI, idx, 5'd0, value[31:16]));
		exec_instr(enc_r(F_SLL, idx, idx, 5'd31));
		exec_instr(enc_i(OP_ORI, idx, idx, value[15:0]));
	endtask

	task automatic check_reg(input reg_idx_t idx);
		word_t data;
		logic  slverr;
		int    cycles;
		apb_write(REG_SEL, {27'b0, idx}, slverr, cycles);
		apb_read(REG_DATA, data);
		check_word($sformatf("%s r%0d", cur_test, idx), model_regs[idx], data);
	endtask

	task automatic start_test(input string name);
		cur_test     = name;
		test_checks0 = n_checks;
		test_errors0 = n_errors;
	endtask

	task automatic end_test();
		$display("test %-12s checks %0d errors %0d", cur_test,
			n_checks - test_checks0, n_errors - test_errors0);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: run timed out after %0d ns in test %s", WATCHDOG_NS, cur_test);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		word_t       value;
		logic [15:0] imm;
		logic [5:0]  opc;
		reg_idx_t    ra;
		logic        err;
		int          cycles;
		opcode_e     op;
		opcode_e     imm_ops [4];
		opcode_e     mem_ops [4];
		apb_req   = '0;
		n_checks  = 0;
		n_errors  = 0;
		t6_checks = 0;
		t6_errors = 0;
		cur_test  = "reset";
		imm_ops   = '{OP_ADDI, OP_ANDI, OP_ORI, OP_XORI};
		mem_ops   = '{OP_ST, OP_STB, OP_LD, OP_LDB};
		for (int r = 0; r < 32; r++) begin
			model_regs[r]   = '0;
			model_shadow[r] = '0;
		end
		void'($urandom(SEED));

		wait (rst === 1'b1);
		wait (rst === 1'b0);
		#(SAMPLE_DELAY);
		test_errors0 = n_errors;
		check_ready("after reset", 1'b0, apb_rsp.pready);
		check_slverr("after reset", 1'b0, apb_rsp.pslverr);
		t6_checks = 2;
		t6_errors = n_errors - test_errors0;

		start_test("alu_rtype");
		for (int i = 1; i <= N_FILL; i++) begin
			load_reg(reg_idx_t'(i), $urandom());
		end
		for (int i = 0; i < N_ALU; i++) begin
			ra = rand_reg(1, 31);
			exec_instr(enc_r(4'($urandom_range(7, 0)), ra, rand_reg(0, 31), rand_reg(0, 31)));
			check_reg(ra);
		end
		end_test();

		start_test("immediate");
		for (int i = 0; i < N_IMM; i++) begin
			imm = 16'($urandom());
			// every other immediate negative.
			imm[15] = i[0];
			ra = rand_reg(1, 30);
			exec_instr(enc_i(imm_ops[(i / 2) % 4], ra, rand_reg(0, 31), imm));
			check_reg(ra);
		end
		end_test();

		start_test("load_store");
		for (int w = 0; w < N_PREFILL; w++) begin
			exec_instr(enc_i(OP_ST, rand_reg(1, 30), 5'd0, 16'(w * 4)));
		end
		for (int i = 0; i < N_MEM; i++) begin
			ra = rand_reg(1, 30);
			op = mem_ops[$urandom_range(3, 0)];
			exec_instr(enc_i(op, ra, 5'd0, 16'($urandom_range(N_PREFILL * 4 - 1, 0))));
			if (op == OP_LD || op == OP_LDB) begin
				check_reg(ra);
			end
		end
		for (int w = 0; w < N_PREFILL; w++) begin
			exec_instr(enc_i(OP_LD, reg_idx_t'(w + 1), 5'd0, 16'(w * 4)));
			check_reg(reg_idx_t'(w + 1));
		end
		end_test();

		start_test("save_restore");
		apb_write(REG_CTRL, 32'h1, err, cycles);
		check_slverr("save_restore save", 1'b0, err);
		model_shadow = model_regs;
		for (int i = 0; i < N_SCRAMBLE; i++) begin
			exec_instr(enc_i(OP_XORI, rand_reg(1, 31), rand_reg(0, 31), 16'($urandom())));
		end
		apb_write(REG_CTRL, 32'h2, err, cycles);
		check_slverr("save_restore restore", 1'b0, err);
		model_regs = model_shadow;
		for (int r = 0; r < 32; r++) begin
			check_reg(reg_idx_t'(r));
		end
		end_test();

		start_test("zero_and_err");
		exec_instr(enc_i(OP_ADDI, 5'd0, 5'd3, 16'h1234));
		check_reg(5'd0);
		exec_instr(enc_r(F_ADD, 5'd0, 5'd4, 5'd5));
		check_reg(5'd0);
		exec_instr(enc_i(OP_LD, 5'd0, 5'd0, 16'h0008));
		check_reg(5'd0);
		exec_instr(enc_i(OP_ORI, 5'd0, 5'd0, 16'hffff));
		check_reg(5'd0);
		// unknown opcodes first, then unused function codes.
		for (int i = 0; i < 8; i++) begin
			if (i < 6) begin
				opc = 6'($urandom());
				while (is_legal_opcode(opc)) begin
					opc = 6'($urandom());
				end
				value = {opc, 26'($urandom())};
			end else begin
				value = enc_r(4'($urandom_range(15, 8)), rand_reg(1, 31),
					rand_reg(0, 31), rand_reg(0, 31));
			end
			exec_instr(value);
			check_reg(value[20:16]);
			check_reg(value[15:11]);
		end
		// out of range addresses that alias words 1 and 2 in a 64 word memory.
		exec_instr(enc_i(OP_ST, 5'd7, 5'd0, 16'h0104));
		exec_instr(enc_i(OP_STB, 5'd8, 5'd0, 16'h0108));
		exec_instr(enc_i(OP_LD, 5'd9, 5'd0, 16'h0104));
		check_reg(5'd9);
		exec_instr(enc_i(OP_LDB, 5'd10, 5'd0, 16'hfff8));
		check_reg(5'd10);
		exec_instr(enc_i(OP_LD, 5'd11, 5'd0, 16'h0004));
		check_reg(5'd11);
		exec_instr(enc_i(OP_LD, 5'd12, 5'd0, 16'h0008));
		check_reg(5'd12);
		end_test();

		$display("test %-12s checks %0d errors %0d", "latency", t6_checks, t6_errors);
		$display("tests 6, checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
source/isa_pkg.sv
source/ctrl_pkg.sv
source/regfile_shadow.sv
source/decode.sv
source/alu.sv
source/data_mem.sv
source/exec_sequencer.sv
source/core_top.sv
verif/tb_clock.sv
verif/core_tb.sv
